/* Makefile */
SRCS := flist.f $(wildcard include/*.svh logic/*.sv verif/*.sv)

obj_dir/Vscope_tb: $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module scope_tb

run: obj_dir/Vscope_tb
	./obj_dir/Vscope_tb | tee sim.log
	grep -q "^TEST PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

/* flist.f */
+incdir+include
logic/scope_pkg.sv
logic/scope_trigger.sv
logic/scope_capture_ctrl.sv
logic/scope_sample_ram.sv
logic/scope_readout.sv
logic/scope_top.sv
verif/scope_clkgen.sv
verif/scope_assertions.sv
verif/scope_tb.sv

/* include/scope_defs.svh */
`ifndef SCOPE_DEFS_SVH
`define SCOPE_DEFS_SVH

// capture buffer geometry
`define SCOPE_ADDR_W 10
`define SCOPE_DEPTH (1 << `SCOPE_ADDR_W)

// one sample word holds both channels
`define SCOPE_SAMPLE_W 32

`endif

/* logic/scope_capture_ctrl.sv */
`timescale 1ns/10ps

`include "scope_defs.svh"

module scope_capture_ctrl (
  input  logic                      aclk,
  input  logic                      aresetn,
  input  logic                      run,
  input  logic                      sample_valid,
  input  scope_pkg::sample_t        sample_data,
  input  logic                      trig_hit,
  input  logic [`SCOPE_ADDR_W:0]    pre_count,
  input  logic [`SCOPE_ADDR_W:0]    total_count,
  output logic                      busy,
  output logic                      done,
  output logic [`SCOPE_ADDR_W-1:0]  trig_addr,
  output logic                      wr_en,
  output logic [`SCOPE_ADDR_W-1:0]  wr_addr,
  output scope_pkg::sample_t        wr_data
);

  scope_pkg::cap_state_t state;

  logic [`SCOPE_ADDR_W-1:0] wr_ptr;
  logic [`SCOPE_ADDR_W:0]   pre_q;
  logic [`SCOPE_ADDR_W:0]   post_len;
  logic [`SCOPE_ADDR_W:0]   fill_cnt;
  logic [`SCOPE_ADDR_W:0]   post_cnt;
  logic [`SCOPE_ADDR_W:0]   fill_next;
  logic [`SCOPE_ADDR_W:0]   post_next;
  logic                     start;

  // every state but idle records each valid sample
  assign busy      = (state != scope_pkg::st_idle);
  assign wr_en     = sample_valid && busy;
  assign wr_addr   = wr_ptr;
  assign wr_data   = sample_data;
  assign start     = run && (state == scope_pkg::st_idle);
  assign fill_next = fill_cnt + 1'b1;
  assign post_next = post_cnt + 1'b1;

  // configuration is taken once per capture
  always_ff @(posedge aclk)
  begin
    if (start)
    begin
      pre_q    <= pre_count;
      post_len <= total_count - pre_count;
    end
  end

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      state     <= scope_pkg::st_idle;
      done      <= 1'b0;
      trig_addr <= '0;
      wr_ptr    <= '0;
      fill_cnt  <= '0;
      post_cnt  <= '0;
    end
    else
    begin
      if (wr_en)
        wr_ptr <= wr_ptr + 1'b1;

      case (state)
        scope_pkg::st_idle:
        begin
          if (run)
          begin
            wr_ptr   <= '0;
            fill_cnt <= '0;
            post_cnt <= '0;
            done     <= 1'b0;
            // no pre-trigger history requested, go straight to armed
            state    <= (pre_count == '0) ? scope_pkg::st_armed : scope_pkg::st_fill;
          end
        end

        scope_pkg::st_fill:
        begin
          if (sample_valid)
          begin
            fill_cnt <= fill_next;
            if (fill_next == pre_q)
              state <= scope_pkg::st_armed;
          end
        end

        scope_pkg::st_armed:
        begin
          if (sample_valid && trig_hit)
          begin
            trig_addr <= wr_ptr;
            post_cnt  <= 1;
            if (post_len == 1)
            begin
              state <= scope_pkg::st_idle;
              done  <= 1'b1;
            end
            else
            begin
              state <= scope_pkg::st_post;
            end
          end
        end

        scope_pkg::st_post:
        begin
          if (sample_valid)
          begin
            post_cnt <= post_next;
            if (post_next == post_len)
            begin
              state <= scope_pkg::st_idle;
              done  <= 1'b1;
            end
          end
        end

        default:
        begin
          state <= scope_pkg::st_idle;
        end
      endcase
    end
  end

endmodule

/* logic/scope_pkg.sv */
`include "scope_defs.svh"

package scope_pkg;

  // upper half is channel a, lower half is channel b
  typedef struct packed {
    logic signed [15:0] ch_a;
    logic signed [15:0] ch_b;
  } chan_pair_t;

  typedef union packed {
    logic [`SCOPE_SAMPLE_W-1:0] raw;
    chan_pair_t                 chan;
  } sample_t;

  typedef enum logic {
    chan_a,
    chan_b
  } chan_sel_t;

  typedef enum logic [1:0] {
    st_idle,
    st_fill,
    st_armed,
    st_post
  } cap_state_t;

endpackage

/* logic/scope_readout.sv */
`timescale 1ns/10ps

`include "scope_defs.svh"

module scope_readout (
  input  logic                      aclk,
  input  logic                      aresetn,
  input  logic                      read_start,
  input  logic                      done,
  input  logic                      busy,
  input  logic [`SCOPE_ADDR_W-1:0]  trig_addr,
  input  logic [`SCOPE_ADDR_W:0]    pre_count,
  input  logic [`SCOPE_ADDR_W:0]    total_count,
  output logic                      rd_en,
  output logic [`SCOPE_ADDR_W-1:0]  rd_addr,
  input  scope_pkg::sample_t        ram_data,
  output logic                      rd_valid,
  output scope_pkg::sample_t        rd_data,
  output logic                      rd_last
);

  logic                   active;
  logic [`SCOPE_ADDR_W:0] remain;
  logic                   last_word;

  assign rd_en     = active;
  assign last_word = active && (remain == 1);

  // RAM output is already aligned with the delayed flags
  assign rd_data   = ram_data;

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      active   <= 1'b0;
      rd_addr  <= '0;
      remain   <= '0;
      rd_valid <= 1'b0;
      rd_last  <= 1'b0;
    end
    else
    begin
      rd_valid <= active;
      rd_last  <= last_word;

      if (active)
      begin
        rd_addr <= rd_addr + 1'b1;
        remain  <= remain - 1'b1;
        if (last_word)
          active <= 1'b0;
      end
      else if (read_start && done && !busy)
      begin
        active  <= 1'b1;
        // oldest pre-trigger sample, wraps modulo the depth
        rd_addr <= trig_addr - pre_count[`SCOPE_ADDR_W-1:0];
        remain  <= total_count;
      end
    end
  end

endmodule

/* logic/scope_sample_ram.sv */
`timescale 1ns/10ps

`include "scope_defs.svh"

module scope_sample_ram (
  input  logic                      aclk,
  input  logic                      wr_en,
  input  logic [`SCOPE_ADDR_W-1:0]  wr_addr,
  input  scope_pkg::sample_t        wr_data,
  input  logic                      rd_en,
  input  logic [`SCOPE_ADDR_W-1:0]  rd_addr,
  output scope_pkg::sample_t        rd_data
);

  logic [`SCOPE_SAMPLE_W-1:0] mem [0:`SCOPE_DEPTH-1];

  always_ff @(posedge aclk)
  begin
    if (wr_en)
      mem[wr_addr] <= wr_data.raw;
  end

  // registered read, data follows rd_en by one cycle
  always_ff @(posedge aclk)
  begin
    if (rd_en)
      rd_data.raw <= mem[rd_addr];
  end

endmodule

/* logic/scope_top.sv */
`timescale 1ns/10ps

`include "scope_defs.svh"

module scope_top (
  input  logic                      aclk,
  input  logic                      aresetn,
  input  logic                      sample_valid,
  input  scope_pkg::sample_t        sample_data,
  input  scope_pkg::chan_sel_t      trig_chan,
  input  logic signed [15:0]        trig_level,
  input  logic [`SCOPE_ADDR_W:0]    pre_count,
  input  logic [`SCOPE_ADDR_W:0]    total_count,
  input  logic                      run,
  input  logic                      read_start,
  output logic                      busy,
  output logic                      done,
  output logic [`SCOPE_ADDR_W-1:0]  trig_addr,
  output logic                      rd_valid,
  output scope_pkg::sample_t        rd_data,
  output logic                      rd_last
);

  logic                     trig_hit;
  logic                     trig_run;
  logic                     wr_en;
  logic [`SCOPE_ADDR_W-1:0] wr_addr;
  scope_pkg::sample_t       wr_data;
  logic                     rd_en;
  logic [`SCOPE_ADDR_W-1:0] rd_addr;
  scope_pkg::sample_t       ram_data;

  // a run that the controller ignores must not disturb the trigger history
  assign trig_run = run && !busy;

  scope_trigger u_trigger (
    .aclk         (aclk),
    .aresetn      (aresetn),
    .run          (trig_run),
    .sample_valid (sample_valid),
    .sample_data  (sample_data),
    .trig_chan    (trig_chan),
    .trig_level   (trig_level),
    .trig_hit     (trig_hit)
  );

  scope_capture_ctrl u_ctrl (
    .aclk         (aclk),
    .aresetn      (aresetn),
    .run          (run),
    .sample_valid (sample_valid),
    .sample_data  (sample_data),
    .trig_hit     (trig_hit),
    .pre_count    (pre_count),
    .total_count  (total_count),
    .busy         (busy),
    .done         (done),
    .trig_addr    (trig_addr),
    .wr_en        (wr_en),
    .wr_addr      (wr_addr),
    .wr_data      (wr_data)
  );

  scope_sample_ram u_ram (
    .aclk    (aclk),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .rd_en   (rd_en),
    .rd_addr (rd_addr),
    .rd_data (ram_data)
  );

  scope_readout u_readout (
    .aclk        (aclk),
    .aresetn     (aresetn),
    .read_start  (read_start),
    .done        (done),
    .busy        (busy),
    .trig_addr   (trig_addr),
    .pre_count   (pre_count),
    .total_count (total_count),
    .rd_en       (rd_en),
    .rd_addr     (rd_addr),
    .ram_data    (ram_data),
    .rd_valid    (rd_valid),
    .rd_data     (rd_data),
    .rd_last     (rd_last)
  );

endmodule

/* logic/scope_trigger.sv */
`timescale 1ns/10ps

module scope_trigger (
  input  logic                 aclk,
  input  logic                 aresetn,
  input  logic                 run,
  input  logic                 sample_valid,
  input  scope_pkg::sample_t   sample_data,
  input  scope_pkg::chan_sel_t trig_chan,
  input  logic signed [15:0]   trig_level,
  output logic                 trig_hit
);

  // one extra bit so the cleared value sits below any 16-bit level
  localparam logic signed [16:0] PREV_CLEAR = {1'b1, 16'h0000};

  logic signed [15:0] cur_val;
  logic signed [16:0] prev_val;

  always_comb
  begin
    if (trig_chan == scope_pkg::chan_a)
      cur_val = sample_data.chan.ch_a;
    else
      cur_val = sample_data.chan.ch_b;
  end

  // rising crossing: now at or above, previous valid sample below
  assign trig_hit = sample_valid && (cur_val >= trig_level) &&
                    (prev_val < trig_level);

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      prev_val <= PREV_CLEAR;
    end
    else if (run)
    begin
      prev_val <= PREV_CLEAR;
    end
    else if (sample_valid)
    begin
      prev_val <= {cur_val[15], cur_val};
    end
  end

endmodule

/* verif/scope_assertions.sv */
`timescale 1ns/10ps

`include "scope_defs.svh"

module scope_assertions (
  input logic                     aclk,
  input logic                     aresetn,
  input logic                     run,
  input scope_pkg::cap_state_t    state,
  input logic                     sample_valid,
  input logic                     trig_hit,
  input logic                     wr_en,
  input logic [`SCOPE_ADDR_W-1:0] wr_ptr,
  input logic                     busy,
  input logic                     done
);

  // without a run the controller stays idle and cannot write
  wr_only_capturing: assert property (
    @(posedge aclk) disable iff (!aresetn)
    ((state == scope_pkg::st_idle) && !run) |=> !wr_en
  ) else $error("buffer write without a run to start the capture");

  done_busy_exclusive: assert property (
    @(posedge aclk) disable iff (!aresetn)
    !(done && busy)
  ) else $error("done and busy high together");

  // leaving armed for post needs a valid sample that hits
  armed_to_post_on_hit: assert property (
    @(posedge aclk) disable iff (!aresetn)
    ((state == scope_pkg::st_armed) && !(sample_valid && trig_hit)) |=>
      (state != scope_pkg::st_post)
  ) else $error("armed to post without a trigger hit");

  wr_ptr_step: assert property (
    @(posedge aclk) disable iff (!aresetn)
    wr_en |=> (wr_ptr == $past(wr_ptr) + 1'b1)
  ) else $error("write pointer did not advance by one on a write");

endmodule

bind scope_capture_ctrl scope_assertions u_assertions (
  .aclk         (aclk),
  .aresetn      (aresetn),
  .run          (run),
  .state        (state),
  .sample_valid (sample_valid),
  .trig_hit     (trig_hit),
  .wr_en        (wr_en),
  .wr_ptr       (wr_ptr),
  .busy         (busy),
  .done         (done)
);

/* verif/scope_clkgen.sv */
`timescale 1ns/10ps

module scope_clkgen (
  output logic aclk,
  output logic aresetn
);

  // 8 ns period
  initial
  begin
    aclk = 1'b0;
    forever #4 aclk = ~aclk;
  end

  // reset low for four rising edges, released just after the edge
  initial
  begin
    aresetn = 1'b0;
    repeat (4) @(posedge aclk);
    #1;
    aresetn = 1'b1;
  end

endmodule

/* verif/scope_tb.sv */
`timescale 1ns/10ps

`include "scope_defs.svh"

module scope_tb;

  localparam int CNT_W   = `SCOPE_ADDR_W + 1;
  localparam int ADDR_W  = `SCOPE_ADDR_W;
  localparam int DEPTH   = `SCOPE_DEPTH;
  localparam int TIMEOUT = 4000;

  logic                     aclk;
  logic                     aresetn;
  logic                     sample_valid;
  scope_pkg::sample_t       sample_data;
  scope_pkg::chan_sel_t     trig_chan;
  logic signed [15:0]       trig_level;
  logic [`SCOPE_ADDR_W:0]   pre_count;
  logic [`SCOPE_ADDR_W:0]   total_count;
  logic                     run;
  logic                     read_start;
  logic                     busy;
  logic                     done;
  logic [`SCOPE_ADDR_W-1:0] trig_addr;
  logic                     rd_valid;
  scope_pkg::sample_t       rd_data;
  logic                     rd_last;

  // model: every sample the capture writes, in order
  scope_pkg::sample_t log_q[$];
  int                 trig_idx;
  logic               fill_crossing;

  scope_clkgen u_clkgen (
    .aclk    (aclk),
    .aresetn (aresetn)
  );

  scope_top uut (.*);

  task automatic abort_run(string msg);
    $display("error: time %0t %s", $time, msg);
    $display("TEST FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_sample(string name, scope_pkg::sample_t got, scope_pkg::sample_t exp);
    if (got !== exp)
      abort_run($sformatf("%s got %h expected %h", name, got.raw, exp.raw));
  endtask

  task automatic check_addr(string name, logic [`SCOPE_ADDR_W-1:0] got,
                            logic [`SCOPE_ADDR_W-1:0] exp);
    if (got !== exp)
      abort_run($sformatf("%s got %h expected %h", name, got, exp));
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    if (got !== exp)
      abort_run($sformatf("%s got %b expected %b", name, got, exp));
  endtask

  // inputs change 1 ns after the edge, outputs are read there too
  task automatic next_cycle();
    @(posedge aclk);
    #1;
  endtask

  // sawtooth per channel with a little noise, so crossings keep coming
  function automatic logic signed [15:0] saw_value(int idx, int step, int phase);
    int v;
    v = ((idx * step + phase) % 512) - 256;
    v = v + int'($urandom % 17) - 8;
    return 16'(v);
  endfunction

  function automatic logic signed [15:0] random_level();
    return 16'(int'($urandom % 301) - 150);
  endfunction

  function automatic logic signed [15:0] channel_value(scope_pkg::sample_t s,
                                                       scope_pkg::chan_sel_t chan);
    return (chan == scope_pkg::chan_a) ? s.chan.ch_a : s.chan.ch_b;
  endfunction

  // history before the first sample of a capture counts as below any level
  function automatic logic crossing_at(int idx, scope_pkg::chan_sel_t chan,
                                       logic signed [15:0] level);
    logic signed [15:0] cur;
    logic signed [15:0] prev;
    cur = channel_value(log_q[idx], chan);
    if (idx == 0)
      return cur >= level;
    prev = channel_value(log_q[idx - 1], chan);
    return (cur >= level) && (prev < level);
  endfunction

  task automatic run_capture(int pre, int total, scope_pkg::chan_sel_t chan,
                             logic signed [15:0] level, int inject_at);
    int   cycles;
    int   idx;
    int   phase_a;
    int   phase_b;
    logic found;
    logic finished;
    phase_a       = int'($urandom % 512);
    phase_b       = int'($urandom % 512);
    found         = 1'b0;
    finished      = 1'b0;
    fill_crossing = 1'b0;
    trig_idx      = 0;
    cycles        = 0;
    log_q.delete();
    pre_count    = CNT_W'(pre);
    total_count  = CNT_W'(total);
    trig_chan    = chan;
    trig_level   = level;
    sample_valid = 1'b0;
    run          = 1'b1;
    next_cycle();
    while (!finished)
    begin
      check_bit("busy", busy, 1'b1);
      check_bit("done", done, 1'b0);
      check_bit("rd_valid", rd_valid, 1'b0);
      if (cycles >= 2 * TIMEOUT)
        abort_run("capture did not finish within the timeout");
      // extra run and read_start pulses land in the middle of the capture
      run          = (inject_at > 0) && (cycles == inject_at);
      read_start   = (inject_at > 0) && (cycles == inject_at);
      sample_valid = ($urandom % 100) < 70;
      sample_data  = make_sample(log_q.size(), phase_a, phase_b);
      if (sample_valid)
      begin
        log_q.push_back(sample_data);
        idx = log_q.size() - 1;
        if (crossing_at(idx, chan, level))
        begin
          if (idx < pre)
            fill_crossing = 1'b1;
          else if (!found)
          begin
            found    = 1'b1;
            trig_idx = idx;
          end
        end
        if (found && (idx == trig_idx + total - pre - 1))
          finished = 1'b1;
      end
      cycles++;
      next_cycle();
    end
    sample_valid = 1'b0;
    run          = 1'b0;
    read_start   = 1'b0;
    cycles       = 0;
    while (done !== 1'b1)
    begin
      if (cycles >= TIMEOUT)
        abort_run("done did not rise after the last post-trigger sample");
      cycles++;
      next_cycle();
    end
    check_bit("busy", busy, 1'b0);
    check_addr("trig_addr", trig_addr, ADDR_W'(trig_idx % DEPTH));
  endtask

  function automatic scope_pkg::sample_t make_sample(int idx, int phase_a, int phase_b);
    scope_pkg::sample_t s;
    s.chan.ch_a = saw_value(idx, 37, phase_a);
    s.chan.ch_b = saw_value(idx, 53, phase_b);
    return s;
  endfunction

  // expected words run from trig_idx - pre up to the last post-trigger sample
  task automatic read_and_check(int pre, int total);
    int cycles;
    read_start = 1'b1;
    next_cycle();
    read_start = 1'b0;
    cycles     = 1;
    while (rd_valid !== 1'b1)
    begin
      if (cycles >= TIMEOUT)
        abort_run("rd_valid did not rise after read_start");
      cycles++;
      next_cycle();
    end
    if (cycles != 2)
      abort_run($sformatf("first rd_valid came %0d cycles after read_start, not 2", cycles));
    for (int k = 0; k < total; k++)
    begin
      check_bit("rd_valid", rd_valid, 1'b1);
      check_sample("rd_data", rd_data, log_q[trig_idx - pre + k]);
      check_bit("rd_last", rd_last, k == total - 1);
      next_cycle();
    end
    check_bit("rd_valid", rd_valid, 1'b0);
    check_bit("rd_last", rd_last, 1'b0);
  endtask

  initial
  begin
    int cycles;
    int pre;
    int total;
    void'($urandom(32'hd063));
    sample_valid = 1'b0;
    sample_data  = '0;
    trig_chan    = scope_pkg::chan_a;
    trig_level   = '0;
    pre_count    = '0;
    total_count  = '0;
    run          = 1'b0;
    read_start   = 1'b0;
    cycles       = 0;
    while (aresetn !== 1'b1)
    begin
      if (cycles >= TIMEOUT)
        abort_run("reset was never released");
      cycles++;
      next_cycle();
    end
    next_cycle();
    check_bit("busy", busy, 1'b0);
    check_bit("done", done, 1'b0);
    check_bit("rd_valid", rd_valid, 1'b0);
    check_addr("trig_addr", trig_addr, '0);

    // no capture yet, so read_start does nothing
    read_start = 1'b1;
    next_cycle();
    read_start = 1'b0;
    repeat (4)
    begin
      next_cycle();
      check_bit("rd_valid", rd_valid, 1'b0);
    end

    repeat (3)
    begin
      total = 2 + int'($urandom % 400);
      pre   = int'($urandom % total);
      run_capture(pre, total, scope_pkg::chan_a, random_level(), 0);
      read_and_check(pre, total);
    end

    // fill spans several sawtooth periods of channel b
    run_capture(60, 200, scope_pkg::chan_b, random_level(), 0);
    check_bit("fill_crossing", fill_crossing, 1'b1);
    read_and_check(60, 200);

    // full-depth capture wraps the ring
    pre = 100 + int'($urandom % 400);
    run_capture(pre, DEPTH, scope_pkg::chan_a, random_level(), 0);
    read_and_check(pre, DEPTH);

    run_capture(30, 150, scope_pkg::chan_b, random_level(), 10);
    read_and_check(30, 150);

    $display("TEST PASS");
    $finish;
  end

endmodule
